//--- verilog/axil_pkg.sv
//////////////////////////////////////////////////////////////////////
// AXI4-Lite bus package
// Bus widths, response codes and per-channel payload structs
//////////////////////////////////////////////////////////////////////

package axil_pkg;

    // Fixed bus geometry for the whole subsystem
    parameter int AXIL_DATA_WIDTH = 32;
    parameter int AXIL_ADDR_WIDTH = 12;
    // One strobe bit per byte lane
    parameter int AXIL_STRB_WIDTH = AXIL_DATA_WIDTH / 8;

    // Response code as carried on B and R
    typedef logic [1:0] axil_resp_t;

    // Only OKAY is ever produced by the RAM
    localparam axil_resp_t AXIL_RESP_OKAY = 2'b00;

    // Address beat, used for both AW and AR
    typedef struct packed {
        logic [AXIL_ADDR_WIDTH-1:0] addr;
        // Protection bits, driven as zero
        logic [2:0]                 prot;
    } axil_aw_t;

    // Write data beat
    typedef struct packed {
        logic [AXIL_DATA_WIDTH-1:0] data;
        logic [AXIL_STRB_WIDTH-1:0] strb;
    } axil_w_t;

    // Read data beat
    typedef struct packed {
        logic [AXIL_DATA_WIDTH-1:0] data;
        axil_resp_t                 resp;
    } axil_r_t;

endpackage

//--- verilog/cmd_pkg.sv
//////////////////////////////////////////////////////////////////////
// Command stream package
// Request and response words on the subsystem's outer ports
//////////////////////////////////////////////////////////////////////

package cmd_pkg;

    // One request, read or write
    typedef struct packed {
        // High for a write, low for a read
        logic                                 is_write;
        // Byte address, low two bits pick a lane only
        logic [axil_pkg::AXIL_ADDR_WIDTH-1:0] addr;
        // Ignored on reads
        logic [axil_pkg::AXIL_DATA_WIDTH-1:0] data;
        logic [axil_pkg::AXIL_STRB_WIDTH-1:0] strb;
    } cmd_t;

    // One response per request, in request order
    typedef struct packed {
        // Echo of the request type
        logic                                 is_write;
        // Read data, zero for a write acknowledge
        logic [axil_pkg::AXIL_DATA_WIDTH-1:0] data;
        axil_pkg::axil_resp_t                 resp;
    } rsp_t;

endpackage

//--- verilog/axil_cmd_master.sv
//////////////////////////////////////////////////////////////////////
// Command master
// Turns stream commands into AXI4-Lite traffic, returns one response
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axil_cmd_master (
    input  logic                 clk,
    input  logic                 rst,
    // Command and response streams
    input  cmd_pkg::cmd_t        cmd,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    output cmd_pkg::rsp_t        rsp,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    // AXI4-Lite master side
    output axil_pkg::axil_aw_t   aw,
    output logic                 aw_valid,
    input  logic                 aw_ready,
    output axil_pkg::axil_w_t    w,
    output logic                 w_valid,
    input  logic                 w_ready,
    input  axil_pkg::axil_resp_t b_resp,
    input  logic                 b_valid,
    output logic                 b_ready,
    output axil_pkg::axil_aw_t   ar,
    output logic                 ar_valid,
    input  logic                 ar_ready,
    input  axil_pkg::axil_r_t    r,
    input  logic                 r_valid,
    output logic                 r_ready
);
    import cmd_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_RESP,
        ST_HOLD
    } state_t;

    state_t state;
    // Command being worked on, stable from accept until the next accept
    cmd_t   cmd_q;
    rsp_t   rsp_q;
    logic   cmd_fire;
    logic   addr_done;
    logic   rsp_beat;

    assign cmd_fire = cmd_valid && cmd_ready;

    // Channel payloads come straight from the held command
    assign aw = '{addr: cmd_q.addr, prot: 3'b000};
    assign ar = '{addr: cmd_q.addr, prot: 3'b000};
    assign w  = '{data: cmd_q.data, strb: cmd_q.strb};

    // AW and W finish on their own, in either order
    assign addr_done = cmd_q.is_write ? ((!aw_valid || aw_ready) && (!w_valid || w_ready))
                                      : ar_ready;

    // Response beat only taken while nothing is waiting downstream
    assign b_ready  = (state == ST_RESP) && cmd_q.is_write && !rsp_valid;
    assign r_ready  = (state == ST_RESP) && !cmd_q.is_write && !rsp_valid;
    assign rsp_beat = (b_valid && b_ready) || (r_valid && r_ready);

    assign rsp = rsp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            cmd_ready <= 1'b0;
            rsp_valid <= 1'b0;
            aw_valid  <= 1'b0;
            w_valid   <= 1'b0;
            ar_valid  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_fire) begin
                        cmd_ready <= 1'b0;
                        // Raise only the channels this command needs
                        aw_valid  <= cmd.is_write;
                        w_valid   <= cmd.is_write;
                        ar_valid  <= !cmd.is_write;
                        state     <= ST_ADDR;
                    end else begin
                        cmd_ready <= 1'b1;
                    end
                end
                ST_ADDR: begin
                    // Drop each valid right after its own handshake
                    if (aw_ready) begin
                        aw_valid <= 1'b0;
                    end
                    if (w_ready) begin
                        w_valid <= 1'b0;
                    end
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                    end
                    if (addr_done) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (rsp_beat) begin
                        rsp_valid <= 1'b1;
                        state     <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    // Reopen for commands as the response leaves
                    if (rsp_ready) begin
                        rsp_valid <= 1'b0;
                        cmd_ready <= 1'b1;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            cmd_q <= cmd;
        end
        if (b_valid && b_ready) begin
            rsp_q <= '{is_write: 1'b1, data: '0, resp: b_resp};
        end else if (r_valid && r_ready) begin
            rsp_q <= '{is_write: 1'b0, data: r.data, resp: r.resp};
        end
    end

    property p_valid_held(v, rdy);
        @(posedge clk) disable iff (rst) v && !rdy |=> v;
    endproperty

    // A new command never overlaps an unsent response
    a_no_cmd_with_rsp: assert property (
        @(posedge clk) disable iff (rst) !(cmd_ready && rsp_valid));
    a_aw_held: assert property (p_valid_held(aw_valid, aw_ready));
    a_w_held:  assert property (p_valid_held(w_valid, w_ready));
    a_ar_held: assert property (p_valid_held(ar_valid, ar_ready));

endmodule

//--- verilog/axil_ram.sv
//////////////////////////////////////////////////////////////////////
// AXI4-Lite block RAM slave
// Byte-strobe writes, optional extra register on the read path
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axil_ram #(
    parameter int PIPELINE_OUTPUT = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    // Write side
    input  axil_pkg::axil_aw_t   aw,
    input  logic                 aw_valid,
    output logic                 aw_ready,
    input  axil_pkg::axil_w_t    w,
    input  logic                 w_valid,
    output logic                 w_ready,
    output axil_pkg::axil_resp_t b_resp,
    output logic                 b_valid,
    input  logic                 b_ready,
    // Read side
    input  axil_pkg::axil_aw_t   ar,
    input  logic                 ar_valid,
    output logic                 ar_ready,
    output axil_pkg::axil_r_t    r,
    output logic                 r_valid,
    input  logic                 r_ready
);
    import axil_pkg::*;

    // Word index drops the byte lane bits
    localparam int LANE_BITS       = $clog2(AXIL_STRB_WIDTH);
    localparam int WORD_ADDR_WIDTH = AXIL_ADDR_WIDTH - LANE_BITS;
    localparam int MEM_DEPTH       = 2 ** WORD_ADDR_WIDTH;

    logic [AXIL_DATA_WIDTH-1:0] mem [MEM_DEPTH];

    logic [WORD_ADDR_WIDTH-1:0] wr_index;
    logic [WORD_ADDR_WIDTH-1:0] rd_index;
    logic                       wr_en;
    logic                       rd_en;
    // First read stage and the optional second one
    logic [AXIL_DATA_WIDTH-1:0] rd_data_q;
    logic                       rd_valid_q;
    logic [AXIL_DATA_WIDTH-1:0] pipe_data_q;
    logic                       pipe_valid_q;
    // First stage empties this cycle
    logic                       stage_drain;

    assign wr_index = aw.addr[AXIL_ADDR_WIDTH-1:LANE_BITS];
    assign rd_index = ar.addr[AXIL_ADDR_WIDTH-1:LANE_BITS];

    initial begin
        for (int k = 0; k < MEM_DEPTH; k++) begin
            mem[k] = '0;
        end
    end

    // Write needs both beats and a free B slot
    // The ready pulse blocks a second take of the same beats
    assign wr_en = aw_valid && w_valid && !aw_ready && (!b_valid || b_ready);

    assign b_resp = AXIL_RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
        end else begin
            aw_ready <= wr_en;
            w_ready  <= wr_en;
            if (wr_en) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    // Byte lanes written one by one under their strobe
    always @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < AXIL_STRB_WIDTH; i++) begin
                if (w.strb[i]) begin
                    mem[wr_index][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

    // With the extra stage, stage one moves on whenever stage two can take it
    assign stage_drain = (PIPELINE_OUTPUT != 0) ? (!pipe_valid_q || r_ready) : r_ready;
    assign rd_en       = ar_valid && !ar_ready && (!rd_valid_q || stage_drain);

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_ready     <= 1'b0;
            rd_valid_q   <= 1'b0;
            pipe_valid_q <= 1'b0;
        end else begin
            ar_ready <= rd_en;
            if (rd_en) begin
                rd_valid_q <= 1'b1;
            end else if (stage_drain) begin
                rd_valid_q <= 1'b0;
            end
            // Skid stage refills when empty or accepted
            if (!pipe_valid_q || r_ready) begin
                pipe_valid_q <= rd_valid_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data_q <= mem[rd_index];
        end
        if (!pipe_valid_q || r_ready) begin
            pipe_data_q <= rd_data_q;
        end
    end

    assign r_valid = (PIPELINE_OUTPUT != 0) ? pipe_valid_q : rd_valid_q;
    assign r       = '{data: (PIPELINE_OUTPUT != 0) ? pipe_data_q : rd_data_q,
                       resp: AXIL_RESP_OKAY};

    // Response beats stay up until the master takes them
    a_b_held: assert property (
        @(posedge clk) disable iff (rst) b_valid && !b_ready |=> b_valid);
    a_r_held: assert property (
        @(posedge clk) disable iff (rst) r_valid && !r_ready |=> r_valid);
    // AW and W are taken together, while both beats are still offered
    a_wr_ready_pair: assert property (
        @(posedge clk) disable iff (rst)
        (aw_ready || w_ready) |-> (aw_ready && w_ready && aw_valid && w_valid));

endmodule

//--- verilog/axil_mem_top.sv
//////////////////////////////////////////////////////////////////////
// Memory subsystem top
// Command master driving an AXI4-Lite RAM
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axil_mem_top #(
    parameter int PIPELINE_OUTPUT = 0
) (
    input  logic          clk,
    input  logic          rst,
    input  cmd_pkg::cmd_t cmd,
    input  logic          cmd_valid,
    output logic          cmd_ready,
    output cmd_pkg::rsp_t rsp,
    output logic          rsp_valid,
    input  logic          rsp_ready
);
    import axil_pkg::*;

    // Write channels
    axil_aw_t   aw;
    logic       aw_valid;
    logic       aw_ready;
    axil_w_t    w;
    logic       w_valid;
    logic       w_ready;
    axil_resp_t b_resp;
    logic       b_valid;
    logic       b_ready;
    // Read channels
    axil_aw_t   ar;
    logic       ar_valid;
    logic       ar_ready;
    axil_r_t    r;
    logic       r_valid;
    logic       r_ready;

    axil_cmd_master axil_cmd_master_inst (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .b_resp    (b_resp),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .r         (r),
        .r_valid   (r_valid),
        .r_ready   (r_ready)
    );

    // Read path depth chosen here
    axil_ram #(
        .PIPELINE_OUTPUT (PIPELINE_OUTPUT)
    ) axil_ram_inst (
        .clk      (clk),
        .rst      (rst),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b_resp   (b_resp),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready)
    );

endmodule

//--- bench/axil_mem_checks.svh
//////////////////////////////////////////////////////////////////////
// Response checks for the memory subsystem testbench
// Typed compare tasks and the counters they keep
//////////////////////////////////////////////////////////////////////

`ifndef AXIL_MEM_CHECKS_SVH
`define AXIL_MEM_CHECKS_SVH

// Running totals for the closing line
int checks_run  = 0;
int error_count = 0;

// One line per wrong value, with the time
task automatic report_mismatch(input string msg);
    error_count++;
    $display("FAILED at %0t ns: %s", $time, msg);
endtask

// Fields compared by name so a bad line says which one
task automatic check_rsp(input rsp_t got, input rsp_t want, input string what);
    checks_run++;
    if (got.is_write !== want.is_write) begin
        report_mismatch($sformatf("%s is_write got %0b expected %0b",
                                  what, got.is_write, want.is_write));
    end
    if (got.data !== want.data) begin
        report_mismatch($sformatf("%s data got %h expected %h", what, got.data, want.data));
    end
    if (got.resp !== want.resp) begin
        report_mismatch($sformatf("%s resp got %0d expected %0d", what, got.resp, want.resp));
    end
endtask

// Single handshake level, e.g. cmd_ready
task automatic check_level(input logic got, input logic want, input string what);
    checks_run++;
    if (got !== want) begin
        report_mismatch($sformatf("%s got %0b expected %0b", what, got, want));
    end
endtask

// Response count against command count
task automatic check_total(input int got, input int want, input string what);
    checks_run++;
    if (got != want) begin
        report_mismatch($sformatf("%s got %0d expected %0d", what, got, want));
    end
endtask

`endif

//--- bench/axil_mem_tb.sv
//////////////////////////////////////////////////////////////////////
// Memory subsystem testbench
// Drives commands, models the RAM and checks every response
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axil_mem_tb #(
    parameter int PIPELINE_OUTPUT = 0
);
    import axil_pkg::*;
    import cmd_pkg::*;

    localparam int LANE_BITS      = $clog2(AXIL_STRB_WIDTH);
    localparam int WORD_BITS      = AXIL_ADDR_WIDTH - LANE_BITS;
    localparam int TIMEOUT_CYCLES = 2000;

    logic clk;
    logic rst;
    cmd_t cmd;
    logic cmd_valid;
    logic cmd_ready;
    rsp_t rsp;
    logic rsp_valid;
    logic rsp_ready;

    // Shadow copy of the RAM words
    logic [AXIL_DATA_WIDTH-1:0] shadow [2**WORD_BITS];
    // Predicted responses in command order
    rsp_t        expected_q [$];
    int          seed;
    logic [31:0] bp_rnd;
    logic        backpressure;
    int          cmd_total;
    int          rsp_total;
    int          test_num;
    int          errors_at_start;

    `include "axil_mem_checks.svh"

    axil_mem_top #(
        .PIPELINE_OUTPUT (PIPELINE_OUTPUT)
    ) axil_mem_top_inst (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reference model, applies strobes per byte like the RAM
    function automatic rsp_t predict_rsp(input cmd_t c);
        rsp_t                 pred;
        logic [WORD_BITS-1:0] idx;
        idx           = c.addr[AXIL_ADDR_WIDTH-1:LANE_BITS];
        pred.is_write = c.is_write;
        pred.resp     = AXIL_RESP_OKAY;
        pred.data     = c.is_write ? '0 : shadow[idx];
        if (c.is_write) begin
            for (int b = 0; b < AXIL_STRB_WIDTH; b++) begin
                if (c.strb[b]) begin
                    shadow[idx][8*b +: 8] = c.data[8*b +: 8];
                end
            end
        end
        return pred;
    endfunction

    function automatic cmd_t make_cmd(input logic is_write, input logic [AXIL_ADDR_WIDTH-1:0] addr,
                                      input logic [AXIL_DATA_WIDTH-1:0] data,
                                      input logic [AXIL_STRB_WIDTH-1:0] strb);
        cmd_t c;
        c.is_write = is_write;
        c.addr     = addr;
        c.data     = data;
        c.strb     = strb;
        return c;
    endfunction

    // Any type, any address, any strobe
    function automatic cmd_t random_cmd();
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $random(seed);
        r2 = $random(seed);
        return make_cmd(r1[31], r1[AXIL_ADDR_WIDTH-1:0], r2, r1[AXIL_ADDR_WIDTH +: AXIL_STRB_WIDTH]);
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("Timeout after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        $display("TEST FAIL");
        $finish;
    endtask

    // Called 1 ns after an edge; holds the command until cmd_ready takes it
    task automatic send_cmd(input cmd_t c);
        int waited;
        waited = 0;
        expected_q.push_back(predict_rsp(c));
        cmd       = c;
        cmd_valid = 1'b1;
        while (!cmd_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_on_timeout("cmd_ready");
            end
        end
        // Transfer happens on this edge
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        cmd_total++;
    endtask

    task automatic start_test();
        test_num++;
        errors_at_start = error_count;
    endtask

    // Waits for every outstanding response, then a few idle cycles for strays
    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_on_timeout($sformatf("responses in test %0d", test_num));
            end
        end
        repeat (4) @(posedge clk);
        #1;
        check_total(rsp_total, cmd_total, "responses against commands");
        $display("Test %0d %s finished: %0d errors", test_num, name,
                 error_count - errors_at_start);
    endtask

    // Ready changes 1 ns after the edge, roughly one cycle in four low
    initial begin
        forever begin
            @(posedge clk);
            #1;
            bp_rnd    = $random(seed);
            rsp_ready = backpressure ? (bp_rnd[0] | bp_rnd[1]) : 1'b1;
        end
    end

    // Compare process, sampled mid-cycle where everything is settled
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && rsp_valid) begin
                check_level(cmd_ready, 1'b0, "cmd_ready while response pending");
            end
            if (!rst && rsp_valid && rsp_ready) begin
                rsp_total++;
                if (expected_q.size() == 0) begin
                    error_count++;
                    $display("A response arrived at %0t ns with no command outstanding", $time);
                end else begin
                    check_rsp(rsp, expected_q.pop_front(), $sformatf("response %0d", rsp_total));
                end
            end
        end
    end

    initial begin
        logic [31:0]                rnd;
        logic [31:0]                data;
        logic [AXIL_ADDR_WIDTH-1:0] addr;
        logic [AXIL_STRB_WIDTH-1:0] strb;
        seed         = 32'h05e7_dd4d;
        rst          = 1'b1;
        cmd          = '0;
        cmd_valid    = 1'b0;
        rsp_ready    = 1'b0;
        backpressure = 1'b0;
        cmd_total    = 0;
        rsp_total    = 0;
        test_num     = 0;
        for (int k = 0; k < 2**WORD_BITS; k++) begin
            shadow[k] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // Untouched memory reads back zero
        start_test();
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            send_cmd(make_cmd(1'b0, rnd[AXIL_ADDR_WIDTH-1:0], '0, '0));
        end
        finish_test("reads after reset");

        start_test();
        for (int i = 0; i < 16; i++) begin
            rnd  = $random(seed);
            data = $random(seed);
            addr = {rnd[AXIL_ADDR_WIDTH-1:LANE_BITS], {LANE_BITS{1'b0}}};
            send_cmd(make_cmd(1'b1, addr, data, '1));
            send_cmd(make_cmd(1'b0, addr, '0, '0));
        end
        finish_test("full write then read");

        // Every strobe pattern that is neither empty nor full
        start_test();
        for (int s = 1; s < 15; s++) begin
            strb = s[AXIL_STRB_WIDTH-1:0];
            rnd  = $random(seed);
            addr = rnd[AXIL_ADDR_WIDTH-1:0];
            send_cmd(make_cmd(1'b1, addr, $random(seed), '1));
            send_cmd(make_cmd(1'b1, addr, $random(seed), strb));
            send_cmd(make_cmd(1'b0, addr, '0, '0));
        end
        finish_test("partial strobes");

        // Read back through a different lane offset of the same word
        start_test();
        for (int i = 0; i < 16; i++) begin
            rnd  = $random(seed);
            addr = rnd[AXIL_ADDR_WIDTH-1:0];
            send_cmd(make_cmd(1'b1, addr, $random(seed), '1));
            addr[LANE_BITS-1:0] = rnd[AXIL_ADDR_WIDTH +: LANE_BITS];
            send_cmd(make_cmd(1'b0, addr, '0, '0));
        end
        finish_test("lane aliasing");

        start_test();
        backpressure = 1'b1;
        for (int i = 0; i < 50; i++) begin
            send_cmd(random_cmd());
        end
        finish_test("response back-pressure");
        backpressure = 1'b0;

        start_test();
        for (int i = 0; i < 200; i++) begin
            send_cmd(random_cmd());
        end
        finish_test("random mix");

        $display("Checks run: %0d, errors: %0d", checks_run, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+bench
verilog/axil_pkg.sv
verilog/cmd_pkg.sv
verilog/axil_cmd_master.sv
verilog/axil_ram.sv
verilog/axil_mem_top.sv
bench/axil_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator, once per read pipeline setting

cd "$(dirname "$0")" || exit 1

status=0
for pipe in 0 1; do
    obj="obj_dir_p${pipe}"
    log="sim_p${pipe}.log"
    echo "Building with PIPELINE_OUTPUT=${pipe}"
    verilator --binary --timing --assert -f filelist.f --top-module axil_mem_tb \
        -GPIPELINE_OUTPUT=${pipe} --Mdir "${obj}" -o axil_mem_sim
    if [ $? -ne 0 ]; then
        echo "Verilator build failed for PIPELINE_OUTPUT=${pipe}"
        exit 1
    fi
    "./${obj}/axil_mem_sim" > "${log}" 2>&1
    if [ $? -ne 0 ]; then
        echo "Simulation exited with an error for PIPELINE_OUTPUT=${pipe}"
        status=1
    fi
    cat "${log}"
    if grep -q "^TEST PASS$" "${log}"; then
        echo "PIPELINE_OUTPUT=${pipe}: passed"
    else
        echo "PIPELINE_OUTPUT=${pipe}: failed"
        status=1
    fi
done
exit ${status}
